// ==== logic/channel_config_if.sv ====
/*
 * Configuration path from the register bank to the channels.
 * The bank drives the staged settings and a one-cycle latch pulse,
 * and each channel picks them up when the selector names it.
 */

`timescale 1ns/1ps

interface channel_config_if;
    import wavegen_pkg::*;

    // One-cycle command to load the staged settings into a channel
    logic latch;
    // Channel that the next latch loads
    channel_index_t selector;
    // Staged settings
    shape_t shape;
    phase_t phase_step;
    sample_t level;

    modport bank (
        output latch, selector, shape, phase_step, level
    );

    modport channel (
        input latch, selector, shape, phase_step, level
    );

endinterface

// ==== logic/channel_shaper.sv ====
/*
 * One waveform channel.
 * Holds the shape, phase step and level latched for this channel, steps a
 * 16-bit phase accumulator on every advance strobe and registers the sample
 * of the new phase. One copy is instantiated per channel.
 */

`timescale 1ns/1ps

module channel_shaper #(
    parameter int CHANNEL_INDEX = 0
) (
    input  logic                clock,
    input  logic                reset,
    channel_config_if.channel   config_bus,
    input  logic                advance,
    output wavegen_pkg::sample_t sample
);
    import wavegen_pkg::*;

    // Latched configuration of this channel
    shape_t  shape;
    phase_t  phase_step;
    sample_t level;

    // Accumulated phase and its value after the next step
    phase_t phase;
    phase_t next_phase;

    // High when the pending latch addresses this channel
    logic selected;

    // Sample value for a given phase and shape
    function automatic sample_t shape_sample(
        input shape_t  kind,
        input phase_t  p,
        input sample_t amplitude
    );
        logic [14:0] ramp;
        sample_t     result;
        // Triangle folds the second half of the period back down
        ramp = p[15] ? ~p[14:0] : p[14:0];
        case (kind)
            // Low half of the period is zero, high half is the level
            SHAPE_SQUARE:   result = p[15] ? amplitude : '0;
            SHAPE_TRIANGLE: result = {ramp, 1'b0};
            // Sawtooth is the raw phase, the level plays no part
            SHAPE_SAWTOOTH: result = sample_t'(p);
            default:        result = '0;
        endcase
        return result;
    endfunction

    // Out of range selectors never match since no channel has that index
    assign selected   = config_bus.latch &&
                        (config_bus.selector == channel_index_t'(CHANNEL_INDEX));
    assign next_phase = phase + phase_step;

    // Configuration load
    always_ff @(posedge clock) begin
        if (reset) begin
            shape      <= SHAPE_SQUARE;
            phase_step <= '0;
            level      <= '0;
        end else if (selected) begin
            shape      <= config_bus.shape;
            phase_step <= config_bus.phase_step;
            level      <= config_bus.level;
        end
    end

    // Phase accumulator
    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= '0;
        end else if (selected) begin
            // A new configuration restarts the waveform from phase zero
            phase <= '0;
        end else if (advance) begin
            phase <= next_phase;
        end
    end

    // Sample register, updated together with the phase step.
    // On a coincident latch the phase restarts and the sample keeps its value
    always_ff @(posedge clock) begin
        if (reset) begin
            sample <= '0;
        end else if (advance && !selected) begin
            sample <= shape_sample(shape, next_phase, level);
        end
    end

endmodule

// ==== logic/frame_serializer.sv ====
/*
 * Frame serializer.
 * Accepts a trigger when idle, strobes advance to all channels, captures
 * their samples and sends the enabled channels in order on a valid/ready
 * stream, marking the final sample with last.
 */

`timescale 1ns/1ps

module frame_serializer #(
    parameter int N_CHANNELS = 4
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    trigger,
    input  wavegen_pkg::reg_data_t                  enable_count,
    input  wavegen_pkg::sample_t [N_CHANNELS-1:0]   samples,
    output logic                                    advance,
    output wavegen_pkg::sample_t                    data,
    output wavegen_pkg::channel_index_t             channel,
    output logic                                    valid,
    output logic                                    last,
    input  logic                                    ready
);
    import wavegen_pkg::*;

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_ADVANCE,
        STATE_CAPTURE,
        STATE_SEND
    } serializer_state_t;

    serializer_state_t state;

    // Channel count of the frame in progress, kept as the index of the last channel
    channel_index_t last_index;
    // Channel currently offered on the output
    channel_index_t send_index;
    // Samples frozen for the whole frame
    sample_t [N_CHANNELS-1:0] snapshot;

    // Enable count limited to the channels that exist
    reg_data_t clamped_count;
    logic      transfer;

    always_comb begin
        if (enable_count > reg_data_t'(N_CHANNELS)) begin
            clamped_count = reg_data_t'(N_CHANNELS);
        end else begin
            clamped_count = enable_count;
        end
    end

    // Outputs decode from registers only, so they stay steady under back-pressure
    assign advance  = (state == STATE_ADVANCE);
    assign valid    = (state == STATE_SEND);
    assign data     = snapshot[send_index];
    assign channel  = send_index;
    assign last     = valid && (send_index == last_index);
    assign transfer = valid && ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= STATE_IDLE;
            last_index <= '0;
            send_index <= '0;
            snapshot   <= '0;
        end else begin
            case (state)
                STATE_IDLE: begin
                    // Triggers while a frame runs are dropped because only this state listens
                    if (trigger && (enable_count != '0)) begin
                        last_index <= channel_index_t'(clamped_count - 1'b1);
                        send_index <= '0;
                        state      <= STATE_ADVANCE;
                    end
                end
                STATE_ADVANCE: begin
                    // Channels step their phase at the end of this cycle
                    state <= STATE_CAPTURE;
                end
                STATE_CAPTURE: begin
                    // Channel sample registers now hold the new phase
                    snapshot <= samples;
                    state    <= STATE_SEND;
                end
                STATE_SEND: begin
                    if (transfer) begin
                        if (send_index == last_index) begin
                            state <= STATE_IDLE;
                        end else begin
                            send_index <= send_index + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== logic/waveform_generator.sv ====
/*
 * Top level of the multi-channel waveform generator.
 * Connects the register bank, one shaper per channel and the frame
 * serializer. Configure through the register port, then pulse trigger
 * to receive one frame of samples on the valid/ready output.
 */

`timescale 1ns/1ps

module waveform_generator #(
    parameter int N_CHANNELS = 4
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         trigger,
    input  wavegen_pkg::reg_address_t    reg_address,
    input  wavegen_pkg::reg_data_t       reg_write_data,
    input  logic                         reg_write,
    output wavegen_pkg::reg_data_t       reg_read_data,
    output wavegen_pkg::sample_t         data,
    output wavegen_pkg::channel_index_t  channel,
    output logic                         valid,
    output logic                         last,
    input  logic                         ready
);
    import wavegen_pkg::*;

    // Staged configuration and latch pulse, shared by all channels
    channel_config_if config_bus ();

    // Number of channels to send per frame, as written by software
    reg_data_t enable_count;
    // Registered sample of every channel
    sample_t [N_CHANNELS-1:0] samples;
    // Phase step strobe from the serializer to all channels
    logic advance;

    wavegen_register_bank u_register_bank (
        .clock          (clock),
        .reset          (reset),
        .reg_address    (reg_address),
        .reg_write_data (reg_write_data),
        .reg_write      (reg_write),
        .reg_read_data  (reg_read_data),
        .enable_count   (enable_count),
        .config_bus     (config_bus.bank)
    );

    // Each channel knows its own index and answers only to that selector
    for (genvar index = 0; index < N_CHANNELS; index++) begin : gen_channel
        channel_shaper #(
            .CHANNEL_INDEX (index)
        ) u_channel_shaper (
            .clock      (clock),
            .reset      (reset),
            .config_bus (config_bus.channel),
            .advance    (advance),
            .sample     (samples[index])
        );
    end

    frame_serializer #(
        .N_CHANNELS (N_CHANNELS)
    ) u_frame_serializer (
        .clock        (clock),
        .reset        (reset),
        .trigger      (trigger),
        .enable_count (enable_count),
        .samples      (samples),
        .advance      (advance),
        .data         (data),
        .channel      (channel),
        .valid        (valid),
        .last         (last),
        .ready        (ready)
    );

endmodule

// ==== logic/wavegen_pkg.sv ====
/*
 * Shared types and constants of the multi-channel waveform generator.
 * Every RTL block and the testbench take their widths, shape codes and
 * register map from here.
 */

package wavegen_pkg;

    // Upper bound on the number of channels a build may instantiate
    localparam int MAX_CHANNELS = 8;

    // One output sample, unsigned
    typedef logic [15:0] sample_t;

    // Phase accumulator and the per-trigger phase step share one width
    typedef logic [15:0] phase_t;

    // Wave shape selector as stored in the shape register
    typedef logic [1:0] shape_t;

    // Shape encodings
    localparam shape_t SHAPE_SQUARE   = 2'd0;
    localparam shape_t SHAPE_TRIANGLE = 2'd1;
    localparam shape_t SHAPE_SAWTOOTH = 2'd2;
    // Channel outputs zero
    localparam shape_t SHAPE_OFF      = 2'd3;

    // Channel number, wide enough to name every channel up to the limit
    typedef logic [$clog2(MAX_CHANNELS)-1:0] channel_index_t;

    // Register port address and data
    typedef logic [2:0]  reg_address_t;
    typedef logic [15:0] reg_data_t;

    // Register map
    localparam reg_address_t ADDR_ENABLE_COUNT = 3'd0;
    localparam reg_address_t ADDR_SHAPE        = 3'd1;
    localparam reg_address_t ADDR_SELECTOR     = 3'd2;
    localparam reg_address_t ADDR_PHASE_STEP   = 3'd3;
    localparam reg_address_t ADDR_LEVEL        = 3'd4;
    // Write only, the written data is ignored and the write itself is the command
    localparam reg_address_t ADDR_LATCH        = 3'd5;

endpackage

// ==== logic/wavegen_register_bank.sv ====
/*
 * Register bank of the waveform generator.
 * Accepts single-cycle register writes, returns registered readback one
 * cycle after the address, and turns a write to the latch address into a
 * latch pulse on the channel configuration bus in the following cycle.
 */

`timescale 1ns/1ps

module wavegen_register_bank (
    input  logic                     clock,
    input  logic                     reset,
    input  wavegen_pkg::reg_address_t reg_address,
    input  wavegen_pkg::reg_data_t   reg_write_data,
    input  logic                     reg_write,
    output wavegen_pkg::reg_data_t   reg_read_data,
    output wavegen_pkg::reg_data_t   enable_count,
    channel_config_if.bank           config_bus
);
    import wavegen_pkg::*;

    // Decoded write strobes, one per register
    logic write_enable_count;
    logic write_shape;
    logic write_selector;
    logic write_phase_step;
    logic write_level;
    logic write_latch;

    assign write_enable_count = reg_write && (reg_address == ADDR_ENABLE_COUNT);
    assign write_shape        = reg_write && (reg_address == ADDR_SHAPE);
    assign write_selector     = reg_write && (reg_address == ADDR_SELECTOR);
    assign write_phase_step   = reg_write && (reg_address == ADDR_PHASE_STEP);
    assign write_level        = reg_write && (reg_address == ADDR_LEVEL);
    assign write_latch        = reg_write && (reg_address == ADDR_LATCH);

    // Configuration registers sit directly on the bus, the channels see the
    // staged values continuously and only sample them on a latch
    always_ff @(posedge clock) begin
        if (reset) begin
            enable_count          <= '0;
            config_bus.shape      <= SHAPE_SQUARE;
            config_bus.selector   <= '0;
            config_bus.phase_step <= '0;
            config_bus.level      <= '0;
            config_bus.latch      <= 1'b0;
        end else begin
            if (write_enable_count) begin
                enable_count <= reg_write_data;
            end
            // Only the low bits carry meaning for shape and selector
            if (write_shape) begin
                config_bus.shape <= shape_t'(reg_write_data);
            end
            if (write_selector) begin
                config_bus.selector <= channel_index_t'(reg_write_data);
            end
            if (write_phase_step) begin
                config_bus.phase_step <= phase_t'(reg_write_data);
            end
            if (write_level) begin
                config_bus.level <= sample_t'(reg_write_data);
            end
            // Registered strobe, so the latch lands one cycle after the command
            config_bus.latch <= write_latch;
        end
    end

    // Readback through a register, the latch address and holes read zero
    always_ff @(posedge clock) begin
        if (reset) begin
            reg_read_data <= '0;
        end else begin
            case (reg_address)
                ADDR_ENABLE_COUNT: reg_read_data <= enable_count;
                ADDR_SHAPE:        reg_read_data <= reg_data_t'(config_bus.shape);
                ADDR_SELECTOR:     reg_read_data <= reg_data_t'(config_bus.selector);
                ADDR_PHASE_STEP:   reg_read_data <= reg_data_t'(config_bus.phase_step);
                ADDR_LEVEL:        reg_read_data <= reg_data_t'(config_bus.level);
                default:           reg_read_data <= '0;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module waveform_generator_tb \
    -f sources.f -o waveform_generator_sim \
    && ./obj_dir/waveform_generator_sim > sim.log 2>&1 \
    || echo "Build or simulation ended with an error" >> sim.log
cat sim.log
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1

// ==== sources.f ====
logic/wavegen_pkg.sv
logic/channel_config_if.sv
logic/wavegen_register_bank.sv
logic/channel_shaper.sv
logic/frame_serializer.sv
logic/waveform_generator.sv
test/waveform_generator_properties.sv
test/waveform_generator_tb.sv

// ==== test/waveform_generator_properties.sv ====
/*
 * Concurrent assertions on the output handshake and the latch pulse of
 * the waveform generator, bound into every instance of the top level.
 */

`timescale 1ns/1ps

module waveform_generator_properties (
    input logic                        clock,
    input logic                        reset,
    input logic                        valid,
    input logic                        ready,
    input logic                        last,
    input logic                        latch,
    input wavegen_pkg::sample_t        data,
    input wavegen_pkg::channel_index_t channel
);

    // A reset cycle leaves the output idle
    valid_low_in_reset: assert property (@(posedge clock) reset |=> !valid)
        else $error("valid is high after a reset cycle");

    // A stalled transfer keeps its payload
    payload_held: assert property (@(posedge clock) disable iff (reset)
        valid && !ready |=> valid && $stable(data) && $stable(channel) && $stable(last))
        else $error("output changed while valid was high and ready low");

    last_with_valid: assert property (@(posedge clock) disable iff (reset) last |-> valid)
        else $error("last is high without valid");

    // Latch commands are single-cycle strobes
    latch_single_cycle: assert property (@(posedge clock) disable iff (reset) latch |=> !latch)
        else $error("latch stayed high for more than one cycle");

endmodule

bind waveform_generator waveform_generator_properties props_i (
    .clock   (clock),
    .reset   (reset),
    .valid   (valid),
    .ready   (ready),
    .last    (last),
    .latch   (config_bus.latch),
    .data    (data),
    .channel (channel)
);

// ==== test/waveform_generator_tb.sv ====
/*
 * Testbench of the waveform generator.
 * Runs the command lines of test/wavegen_stim.txt against the DUT, keeps a
 * model of the staged registers and of every channel, and checks readback
 * values and the content, order and last flag of every output frame.
 */

`timescale 1ns/1ps

module waveform_generator_tb;
    import wavegen_pkg::*;

    localparam int N_CHANNELS = 4;
    localparam int CLOCK_PERIOD = 20;

    logic clock = 1'b0;
    logic reset;
    logic trigger;
    reg_address_t reg_address;
    reg_data_t reg_write_data;
    logic reg_write;
    reg_data_t reg_read_data;
    sample_t data;
    channel_index_t channel;
    logic valid;
    logic last;
    logic ready;

    // Model of the staged registers, indexed by register address
    reg_data_t model_regs [0:4];
    // Model of each channel after its last latch
    shape_t model_shape [N_CHANNELS];
    phase_t model_step [N_CHANNELS];
    sample_t model_level [N_CHANNELS];
    phase_t model_phase [N_CHANNELS];

    string stim_lines [$];
    logic stim_loaded = 1'b0;
    int errors = 0;
    int checks = 0;
    // Share of cycles with ready low, in percent
    int low_percent = 0;
    int seed = 32'had8f_d2f5;

    waveform_generator #(
        .N_CHANNELS (N_CHANNELS)
    ) dut_i (
        .clock          (clock),
        .reset          (reset),
        .trigger        (trigger),
        .reg_address    (reg_address),
        .reg_write_data (reg_write_data),
        .reg_write      (reg_write),
        .reg_read_data  (reg_read_data),
        .data           (data),
        .channel        (channel),
        .valid          (valid),
        .last           (last),
        .ready          (ready)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Sample for a phase, following the shape rules of the generator
    function automatic sample_t expected_sample(shape_t kind, phase_t p, sample_t amplitude);
        sample_t folded;
        // Second half of the period counts back down for the triangle
        folded = (p < 16'h8000) ? p : 16'hffff - p;
        case (kind)
            SHAPE_SQUARE:   return (p >= 16'h8000) ? amplitude : 16'h0000;
            SHAPE_TRIANGLE: return folded << 1;
            SHAPE_SAWTOOTH: return p;
            default:        return 16'h0000;
        endcase
    endfunction

    // One register write; a latch command also loads the model channel
    task automatic write_register(input reg_address_t address, input reg_data_t value);
        int sel;
        @(posedge clock);
        reg_address <= address;
        reg_write_data <= value;
        reg_write <= 1'b1;
        @(posedge clock);
        reg_write <= 1'b0;
        sel = int'(model_regs[ADDR_SELECTOR]);
        if (address == ADDR_LATCH && sel < N_CHANNELS) begin
            model_shape[sel] = shape_t'(model_regs[ADDR_SHAPE]);
            model_step[sel] = model_regs[ADDR_PHASE_STEP];
            model_level[sel] = model_regs[ADDR_LEVEL];
            model_phase[sel] = 16'h0000;
        end else if (address == ADDR_SHAPE) begin
            model_regs[address] = value & 16'h0003;
        end else if (address == ADDR_SELECTOR) begin
            model_regs[address] = value & 16'h0007;
        end else if (address < ADDR_LATCH) begin
            model_regs[address] = value;
        end
    endtask

    // Readback is registered, so the value is checked one cycle after the address
    task automatic check_readback(input reg_address_t address, input reg_data_t expected);
        @(posedge clock);
        reg_address <= address;
        @(posedge clock);
        @(negedge clock);
        checks++;
        if (reg_read_data !== expected) begin
            errors++;
            $display("MISMATCH at %0t: reg_read_data (address %0d) expected %h, got %h",
                     $time, address, expected, reg_read_data);
        end
    endtask

    // Trigger one frame and check every transfer; retrigger pulses trigger mid-frame
    task automatic run_frame(input logic retrigger);
        int count;
        int received;
        int cycles;
        sample_t expected;
        count = int'(model_regs[ADDR_ENABLE_COUNT]);
        if (count > N_CHANNELS) count = N_CHANNELS;
        @(posedge clock);
        trigger <= 1'b1;
        @(posedge clock);
        trigger <= 1'b0;
        if (count == 0) begin
            // An ignored trigger must leave the output quiet
            repeat (20) begin
                @(negedge clock);
                checks++;
                if (valid) begin
                    errors++;
                    $display("Output became valid at %0t although enable count is zero", $time);
                end
            end
        end else begin
            for (int i = 0; i < N_CHANNELS; i++) model_phase[i] = model_phase[i] + model_step[i];
            received = 0;
            cycles = 0;
            while (received < count && cycles < 100 * count) begin
                @(posedge clock);
                ready <= ($unsigned($random(seed)) % 100) >= low_percent;
                trigger <= retrigger && (cycles == 0);
                cycles++;
                // Values seen here are the ones the next rising edge transfers
                @(negedge clock);
                if (valid && ready) begin
                    expected = expected_sample(model_shape[received], model_phase[received],
                                               model_level[received]);
                    checks++;
                    if (channel !== channel_index_t'(received)) begin
                        errors++;
                        $display("MISMATCH at %0t: channel expected %0d, got %0d",
                                 $time, received, channel);
                    end
                    if (data !== expected) begin
                        errors++;
                        $display("MISMATCH at %0t: data expected %h, got %h", $time, expected, data);
                    end
                    if (last !== (received == count - 1)) begin
                        errors++;
                        $display("MISMATCH at %0t: last expected %b, got %b",
                                 $time, received == count - 1, last);
                    end
                    received++;
                end
            end
            if (received < count) begin
                errors++;
                $display("Frame at %0t delivered only %0d of %0d samples", $time, received, count);
            end
        end
    endtask

    initial begin
        int fd;
        string line;
        byte kind;
        logic [31:0] a;
        logic [31:0] b;
        reset = 1'b1;
        trigger = 1'b0;
        reg_address = '0;
        reg_write_data = '0;
        reg_write = 1'b0;
        ready = 1'b1;
        for (int i = 0; i < 5; i++) model_regs[i] = 16'h0000;
        for (int i = 0; i < N_CHANNELS; i++) begin
            model_shape[i] = SHAPE_SQUARE;
            model_step[i] = 16'h0000;
            model_level[i] = 16'h0000;
            model_phase[i] = 16'h0000;
        end
        fd = $fopen("test/wavegen_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the stimulus file test/wavegen_stim.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
                    stim_lines.push_back(line);
            end
            $fclose(fd);
        end
        stim_loaded = 1'b1;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        checks++;
        if (valid !== 1'b0 || last !== 1'b0) begin
            errors++;
            $display("MISMATCH at %0t: valid/last expected 0/0, got %b/%b", $time, valid, last);
        end
        foreach (stim_lines[i]) begin
            kind = stim_lines[i].getc(0);
            a = '0;
            b = '0;
            if (stim_lines[i].len() > 2)
                void'($sscanf(stim_lines[i].substr(2, stim_lines[i].len() - 1), "%h %h", a, b));
            case (kind)
                "W": write_register(reg_address_t'(a), reg_data_t'(b));
                "R": check_readback(reg_address_t'(a), reg_data_t'(b));
                "T": run_frame(1'b0);
                "D": run_frame(1'b1);
                "B": low_percent = int'(a);
                default: begin
                    errors++;
                    $display("Unknown stimulus command in line %0d: %s", i, stim_lines[i]);
                end
            endcase
        end
        repeat (5) @(posedge clock);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Each stimulus line gets a generous budget of cycles
    initial begin
        wait (stim_loaded);
        repeat ((stim_lines.size() + 1) * 200) @(posedge clock);
        $display("Watchdog expired before the stimulus finished at %0t", $time);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== test/wavegen_stim.txt ====
# All fields hex. W addr data: write.  R addr value: readback check.  B pct: ready low percent.
# T: trigger and check one frame.  D: the same with a second trigger during the frame.
R 0 0000
R 1 0000
R 2 0000
R 3 0000
R 4 0000
W 0 0004
W 3 4000
W 4 1234
W 5 0000
W 1 0001
W 3 3000
W 2 0001
W 5 0000
W 1 0002
W 3 1111
W 2 0002
W 5 0000
W 1 0003
W 2 0003
W 5 0000
W 2 0007
W 5 0000
R 0 0004
R 1 0003
R 2 0007
R 3 1111
R 4 1234
R 5 0000
T
T
B 20
T
D
T
W 0 0009
T
W 0 0002
T
W 0 0000
T
W 0 0004
W 1 0002
W 2 0000
W 5 0000
T
